//--- hdl/deser_pkg.sv
// Flow deserializer shared definitions
// Default bus widths, the default reconstruction order and the helper that
// sizes the slot index for a given deserialization ratio

package deser_pkg;

  // ---------------------------------------------------------------------
  // Default widths
  // ---------------------------------------------------------------------

  // Narrow flit width on the push side
  localparam int DEFAULT_PUSH_WIDTH = 8;

  // Wide flit width on the pop side, a whole multiple of the push width
  localparam int DEFAULT_POP_WIDTH = 32;

  // Sideband metadata width, carried through without serialization
  localparam int DEFAULT_META_WIDTH = 3;

  // ---------------------------------------------------------------------
  // Ordering
  // ---------------------------------------------------------------------

  // When set, the first push flit of a pop flit lands in the most
  // significant slice of the pop word
  // When clear, the first push flit lands in the least significant slice
  localparam bit DEFAULT_MSB_FIRST = 1'b1;

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------

  // Width of the slot index that counts push flits within one pop flit
  // Vectors cannot be zero wide, so the result never drops below 1
  function automatic int slot_width(input int ratio);
    int width;
    width = (ratio > 1) ? $clog2(ratio) : 1;
    return width;
  endfunction

endpackage

//--- hdl/flit_lane_if.sv
// Flit lane
// Carries the live push flit and its slot position from the sequencer to
// the staging registers and to the pop word assembler

`timescale 1ns/100ps

interface flit_lane_if #(
  parameter int PUSH_WIDTH = deser_pkg::DEFAULT_PUSH_WIDTH,
  parameter int RATIO      = deser_pkg::DEFAULT_POP_WIDTH / deser_pkg::DEFAULT_PUSH_WIDTH
);

  localparam int SLOT_WIDTH = deser_pkg::slot_width(RATIO);

  // Push valid, straight from the push port
  logic                  flit_valid;
  // Push data of the flit currently presented
  logic [PUSH_WIDTH-1:0] flit_data;
  // Flit ends the packet and so also ends the pop flit
  logic                  flit_last;
  // Position of the presented flit inside the pop flit being built
  logic [SLOT_WIDTH-1:0] slot;
  // Push handshake fires this cycle
  logic                  accept;

  // Sequencer owns the lane
  modport seq (
    output flit_valid,
    output flit_data,
    output flit_last,
    output slot,
    output accept
  );

  // Stager only needs what decides a load and what gets loaded
  modport stage (
    input flit_data,
    input slot,
    input accept,
    input flit_last
  );

  // Assembler builds the pop word combinationally from the live flit
  modport assemble (
    input flit_valid,
    input flit_data,
    input flit_last,
    input slot
  );

endinterface

//--- hdl/flit_sequencer.sv
// Flit sequencer
// Push side of the deserializer: counts push flits within the current pop
// flit, decides when a push flit may be accepted and publishes it on the lane

`timescale 1ns/100ps

module flit_sequencer #(
  parameter int PUSH_WIDTH = deser_pkg::DEFAULT_PUSH_WIDTH,
  parameter int RATIO      = deser_pkg::DEFAULT_POP_WIDTH / deser_pkg::DEFAULT_PUSH_WIDTH
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  push_valid,
  input  logic                  push_last,
  input  logic                  pop_fire,
  input  logic                  pop_ready,
  output logic                  push_ready,
  flit_lane_if.seq              lane,
  input  logic [PUSH_WIDTH-1:0] push_data
);

  localparam int SLOT_WIDTH = deser_pkg::slot_width(RATIO);
  localparam logic [SLOT_WIDTH-1:0] LAST_SLOT = SLOT_WIDTH'(RATIO - 1);

  logic [SLOT_WIDTH-1:0] slot_q;
  logic                  can_stage;
  logic                  can_complete;
  logic                  accept;

  // ---------------------------------------------------------------------
  // Push handshake
  // ---------------------------------------------------------------------

  // A flit that does not finish the pop flit goes into a staging register,
  // which is always free while there are slots left before the last one
  assign can_stage = !(push_valid && push_last) && (slot_q < LAST_SLOT);

  // A flit that finishes the pop flit leaves together with the pop word,
  // so it can only be taken when the pop side takes the word
  assign can_complete = pop_ready && (push_last || (slot_q == LAST_SLOT));

  assign push_ready = can_stage || can_complete;
  assign accept     = push_valid && push_ready;

  // ---------------------------------------------------------------------
  // Slot counter
  // ---------------------------------------------------------------------

  // Counts accepted flits within one pop flit
  // A pop always coincides with an accepted completing flit, so pop_fire
  // takes priority and starts the next pop flit at slot 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_q <= '0;
    end else if (pop_fire) begin
      slot_q <= '0;
    end else if (accept) begin
      slot_q <= slot_q + SLOT_WIDTH'(1);
    end
  end

  // ---------------------------------------------------------------------
  // Lane outputs
  // ---------------------------------------------------------------------

  // The live flit is passed on unregistered so that a completing flit
  // reaches the pop side in the same cycle
  assign lane.flit_valid = push_valid;
  assign lane.flit_data  = push_data;
  assign lane.flit_last  = push_last;
  assign lane.slot       = slot_q;
  assign lane.accept     = accept;

endmodule

//--- hdl/slice_stager.sv
// Slice stager
// Holds the slices of a pop flit that arrive before the completing flit,
// one load-enabled register per slot except the final slot

`timescale 1ns/100ps

module slice_stager #(
  parameter int PUSH_WIDTH = deser_pkg::DEFAULT_PUSH_WIDTH,
  parameter int RATIO      = deser_pkg::DEFAULT_POP_WIDTH / deser_pkg::DEFAULT_PUSH_WIDTH
) (
  input  logic                               clk,
  input  logic                               arst_n,
  flit_lane_if.stage                         lane,
  output logic [RATIO-2:0][PUSH_WIDTH-1:0]   staged
);

  localparam int SLOT_WIDTH = deser_pkg::slot_width(RATIO);

  // One load enable per staging register
  logic [RATIO-2:0] load_en;

  // ---------------------------------------------------------------------
  // Demux into staging registers
  // ---------------------------------------------------------------------

  for (genvar i = 0; i < RATIO - 1; i++) begin : gen_slice

    // Only accepted flits that do not end the packet are stored
    // A last flit passes straight through to the assembler, and the final
    // slot has no register at all since its flit always completes the word
    assign load_en[i] = lane.accept && !lane.flit_last &&
                        (lane.slot == SLOT_WIDTH'(i));

    // Slices not reloaded keep their old contents, which is what shows up
    // in the don't-care part of a short last pop flit
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        staged[i] <= '0;
      end else if (load_en[i]) begin
        staged[i] <= lane.flit_data;
      end
    end

  end

endmodule

//--- hdl/pop_assembler.sv
// Pop assembler
// Pop side of the deserializer: merges staged slices with the live flit into
// the pop word and forms pop valid, last, don't-care count and metadata

`timescale 1ns/100ps

module pop_assembler #(
  parameter int PUSH_WIDTH = deser_pkg::DEFAULT_PUSH_WIDTH,
  parameter int POP_WIDTH  = deser_pkg::DEFAULT_POP_WIDTH,
  parameter int META_WIDTH = deser_pkg::DEFAULT_META_WIDTH,
  parameter int RATIO      = deser_pkg::DEFAULT_POP_WIDTH / deser_pkg::DEFAULT_PUSH_WIDTH,
  parameter bit MSB_FIRST  = deser_pkg::DEFAULT_MSB_FIRST
) (
  flit_lane_if.assemble                              lane,
  input  logic [RATIO-2:0][PUSH_WIDTH-1:0]           staged,
  input  logic [META_WIDTH-1:0]                      push_metadata,
  input  logic                                       pop_ready,
  output logic                                       pop_valid,
  output logic [POP_WIDTH-1:0]                       pop_data,
  output logic                                       pop_last,
  output logic [deser_pkg::slot_width(RATIO)-1:0]    pop_dont_care_count,
  output logic [META_WIDTH-1:0]                      pop_metadata,
  output logic                                       pop_fire
);

  localparam int SLOT_WIDTH = deser_pkg::slot_width(RATIO);
  localparam logic [SLOT_WIDTH-1:0] LAST_SLOT = SLOT_WIDTH'(RATIO - 1);

  // The presented flit fills the final slot or ends the packet early
  logic completes;

  assign completes = lane.flit_last || (lane.slot == LAST_SLOT);

  // ---------------------------------------------------------------------
  // Pop word
  // ---------------------------------------------------------------------

  for (genvar i = 0; i < RATIO; i++) begin : gen_slice
    // Slot 0 sits at the top of the word when MSB first, else at the bottom
    localparam int LSB = MSB_FIRST ? (RATIO - 1 - i) * PUSH_WIDTH : i * PUSH_WIDTH;

    if (i < RATIO - 1) begin : gen_mux
      // The completing flit goes into its own slot directly, all other
      // slots come from the staging registers
      assign pop_data[LSB +: PUSH_WIDTH] =
        (completes && (lane.slot == SLOT_WIDTH'(i))) ? lane.flit_data : staged[i];
    end else begin : gen_live
      // Final slot has no register behind it
      assign pop_data[LSB +: PUSH_WIDTH] = lane.flit_data;
    end
  end

  // ---------------------------------------------------------------------
  // Pop control and sideband
  // ---------------------------------------------------------------------

  // Zero latency: the pop word is valid while its completing flit is shown
  assign pop_valid = lane.flit_valid && completes;
  assign pop_last  = lane.flit_last;

  // Slots after the last filled one are don't care on a short last flit
  assign pop_dont_care_count = pop_last ? (LAST_SLOT - lane.slot) : '0;

  // Metadata is constant over a packet, so the completing flit's copy is used
  assign pop_metadata = push_metadata;

  assign pop_fire = pop_valid && pop_ready;

endmodule

//--- hdl/flow_deserializer.sv
// Flow deserializer
// Collects up to RATIO narrow push flits into one wide pop flit with
// ready/valid on both sides, early completion by push_last and a
// don't-care slice count for a partly filled last pop flit

`timescale 1ns/100ps

module flow_deserializer #(
  parameter int PUSH_WIDTH = deser_pkg::DEFAULT_PUSH_WIDTH,
  parameter int POP_WIDTH  = deser_pkg::DEFAULT_POP_WIDTH,
  parameter int META_WIDTH = deser_pkg::DEFAULT_META_WIDTH,
  parameter bit MSB_FIRST  = deser_pkg::DEFAULT_MSB_FIRST,
  localparam int RATIO      = POP_WIDTH / PUSH_WIDTH,
  localparam int SLOT_WIDTH = deser_pkg::slot_width(RATIO)
) (
  input  logic                  clk,
  input  logic                  arst_n,

  // Push side, narrow flits
  input  logic                  push_valid,
  input  logic [PUSH_WIDTH-1:0] push_data,
  input  logic                  push_last,
  input  logic [META_WIDTH-1:0] push_metadata,
  output logic                  push_ready,

  // Pop side, wide flits
  output logic                  pop_valid,
  output logic [POP_WIDTH-1:0]  pop_data,
  output logic                  pop_last,
  output logic [SLOT_WIDTH-1:0] pop_dont_care_count,
  output logic [META_WIDTH-1:0] pop_metadata,
  input  logic                  pop_ready
);

  // ---------------------------------------------------------------------
  // Elaboration checks
  // ---------------------------------------------------------------------

  if ((POP_WIDTH % PUSH_WIDTH) != 0) begin : gen_bad_width
    $error("POP_WIDTH must be a whole multiple of PUSH_WIDTH");
  end

  if (RATIO < 2) begin : gen_bad_ratio
    $error("POP_WIDTH must be at least twice PUSH_WIDTH");
  end

  // ---------------------------------------------------------------------
  // Internal connections
  // ---------------------------------------------------------------------

  flit_lane_if #(
    .PUSH_WIDTH (PUSH_WIDTH),
    .RATIO      (RATIO)
  ) lane ();

  logic                             pop_fire;
  logic [RATIO-2:0][PUSH_WIDTH-1:0] staged;

  // Input side: slot counting and push handshake
  flit_sequencer #(
    .PUSH_WIDTH (PUSH_WIDTH),
    .RATIO      (RATIO)
  ) u_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_last  (push_last),
    .pop_fire   (pop_fire),
    .pop_ready  (pop_ready),
    .push_ready (push_ready),
    .lane       (lane.seq),
    .push_data  (push_data)
  );

  // Staging registers for all slots but the final one
  slice_stager #(
    .PUSH_WIDTH (PUSH_WIDTH),
    .RATIO      (RATIO)
  ) u_stager (
    .clk    (clk),
    .arst_n (arst_n),
    .lane   (lane.stage),
    .staged (staged)
  );

  // Output side: pop word ordering and pop handshake
  pop_assembler #(
    .PUSH_WIDTH (PUSH_WIDTH),
    .POP_WIDTH  (POP_WIDTH),
    .META_WIDTH (META_WIDTH),
    .RATIO      (RATIO),
    .MSB_FIRST  (MSB_FIRST)
  ) u_assembler (
    .lane                (lane.assemble),
    .staged              (staged),
    .push_metadata       (push_metadata),
    .pop_ready           (pop_ready),
    .pop_valid           (pop_valid),
    .pop_data            (pop_data),
    .pop_last            (pop_last),
    .pop_dont_care_count (pop_dont_care_count),
    .pop_metadata        (pop_metadata),
    .pop_fire            (pop_fire)
  );

endmodule

//--- testbench/flow_deserializer_assert.sv
// Flow deserializer protocol checks
// Concurrent assertions on the pop side, bound into the top level

`timescale 1ns/100ps

module flow_deserializer_assert #(
  parameter int POP_WIDTH  = 32,
  parameter int SLOT_WIDTH = 2
) (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  push_valid,
  input logic                  pop_valid,
  input logic                  pop_ready,
  input logic                  pop_last,
  input logic [SLOT_WIDTH-1:0] pop_dont_care_count,
  input logic [POP_WIDTH-1:0]  pop_data
);

  // Number of assertion failures seen so far
  int failures = 0;

  // ---------------------------------------------------------------------
  // Pop side properties
  // ---------------------------------------------------------------------

  // The pop word only exists while its completing push flit is presented
  a_pop_needs_push: assert property (@(posedge clk) disable iff (!arst_n)
    pop_valid |-> push_valid)
    else begin
      failures++;
      $error("pop_valid is high while push_valid is low");
    end

  // A full pop flit has no don't-care slices
  a_full_no_dont_care: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_last) |-> (pop_dont_care_count == '0))
    else begin
      failures++;
      $error("pop_dont_care_count is not zero on a pop flit without pop_last");
    end

  // Stalled pop flit stays put until the pop side takes it
  a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)))
    else begin
      failures++;
      $error("pop flit changed or dropped while pop_ready was low");
    end

endmodule

bind flow_deserializer flow_deserializer_assert #(
  .POP_WIDTH  (POP_WIDTH),
  .SLOT_WIDTH (SLOT_WIDTH)
) u_assert (
  .clk                 (clk),
  .arst_n              (arst_n),
  .push_valid          (push_valid),
  .pop_valid           (pop_valid),
  .pop_ready           (pop_ready),
  .pop_last            (pop_last),
  .pop_dont_care_count (pop_dont_care_count),
  .pop_data            (pop_data)
);

//--- testbench/tb_flow_deserializer.sv
// Flow deserializer testbench
// Replays push flits from the pattern file under random pop stalls and
// checks each pop flit against the expected records of the same file

`timescale 1ns/100ps

module tb_flow_deserializer;

  localparam int CLK_PERIOD   = 20;
  localparam int MEM_DEPTH    = 64;
  localparam int WAIT_TIMEOUT = 200;
  localparam logic [3:0] KIND_PUSH = 4'ha;
  localparam logic [3:0] KIND_POP  = 4'he;

  logic        clk;
  logic        arst_n;
  logic        push_valid;
  logic [7:0]  push_data;
  logic        push_last;
  logic [2:0]  push_metadata;
  logic        push_ready;
  logic        pop_valid;
  logic [31:0] pop_data;
  logic        pop_last;
  logic [1:0]  pop_dont_care_count;
  logic [2:0]  pop_metadata;
  logic        pop_ready;

  int          seed = 32'h224f_47f9;
  int          pop_idx;
  // Record layout is kind, last, don't-care count, metadata and data
  logic [47:0] pattern_mem [MEM_DEPTH];
  logic [47:0] push_q [$];
  logic [47:0] pop_q [$];

  flow_deserializer #(
    .PUSH_WIDTH (8),
    .POP_WIDTH  (32),
    .META_WIDTH (3),
    .MSB_FIRST  (1'b1)
  ) uut (
    .clk                 (clk),
    .arst_n              (arst_n),
    .push_valid          (push_valid),
    .push_data           (push_data),
    .push_last           (push_last),
    .push_metadata       (push_metadata),
    .push_ready          (push_ready),
    .pop_valid           (pop_valid),
    .pop_data            (pop_data),
    .pop_last            (pop_last),
    .pop_dont_care_count (pop_dont_care_count),
    .pop_metadata        (pop_metadata),
    .pop_ready           (pop_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Pop side takes a word in about three cycles out of four
  always @(posedge clk) begin
    pop_ready <= (({$random(seed)} % 4) != 0);
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_value_error(input string test, input logic [31:0] expected,
                                    input logic [31:0] actual);
    $display("** Error [%s] expected %h, actual %h", test, expected, actual);
    abort_run();
  endtask

  // Splits the pattern file into push records and expected pop records
  task automatic load_patterns();
    for (int i = 0; i < MEM_DEPTH; i++) begin
      pattern_mem[i] = '0;
    end
    $readmemh("testbench/deser_patterns.txt", pattern_mem);
    for (int i = 0; i < MEM_DEPTH; i++) begin
      if (pattern_mem[i][47:44] == KIND_PUSH) begin
        push_q.push_back(pattern_mem[i]);
      end else if (pattern_mem[i][47:44] == KIND_POP) begin
        pop_q.push_back(pattern_mem[i]);
      end
    end
  endtask

  // Presents one push flit and holds it until the DUT accepts it
  task automatic push_flit(input logic [47:0] rec);
    int waited;
    @(posedge clk);
    push_valid    <= 1'b1;
    push_data     <= rec[7:0];
    push_last     <= rec[40];
    push_metadata <= rec[34:32];
    waited = 0;
    @(negedge clk);
    while (!push_ready) begin
      waited++;
      if (waited > WAIT_TIMEOUT) begin
        $display("Timeout while waiting for push_ready on a push flit");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // Compares the pop flit that fires on the next edge with its record
  task automatic check_pop();
    logic [47:0] rec;
    logic [31:0] mask;
    string       name;
    if (pop_idx >= pop_q.size()) begin
      $display("A pop flit fired after every expected pop flit was seen");
      abort_run();
    end else begin
      rec  = pop_q[pop_idx];
      name = $sformatf("pop_flit_%0d", pop_idx);
      // Don't-care slices sit at the bottom of the word and are skipped
      mask = 32'hffff_ffff << (int'(rec[39:36]) * 8);
      assert ((pop_data & mask) == (rec[31:0] & mask))
        else report_value_error({name, " data"}, rec[31:0] & mask, pop_data & mask);
      assert (pop_last == rec[40])
        else report_value_error({name, " last"}, 32'(rec[40]), 32'(pop_last));
      assert (pop_dont_care_count == rec[37:36])
        else report_value_error({name, " dont_care_count"}, 32'(rec[37:36]),
                                32'(pop_dont_care_count));
      assert (pop_metadata == rec[34:32])
        else report_value_error({name, " metadata"}, 32'(rec[34:32]), 32'(pop_metadata));
      pop_idx++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Pop monitor
  // ---------------------------------------------------------------------

  always @(negedge clk) begin
    if (uut.u_assert.failures != 0) begin
      $display("A protocol assertion on the DUT failed");
      abort_run();
    end
    if (arst_n && pop_valid) begin
      if (pop_ready) begin
        check_pop();
      end else begin
        // A completing flit must wait for the pop side
        assert (!push_ready) else begin
          $display("push_ready was high on a completing flit while pop_ready was low");
          abort_run();
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------

  initial begin
    int waited;
    clk           = 1'b0;
    arst_n        = 1'b0;
    push_valid    = 1'b0;
    push_data     = '0;
    push_last     = 1'b0;
    push_metadata = '0;
    pop_ready     = 1'b0;
    pop_idx       = 0;
    load_patterns();
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    // Idle DUT right after reset
    @(negedge clk);
    assert (push_ready && !pop_valid) else begin
      $display("After reset push_ready is not high or pop_valid is not low");
      abort_run();
    end

    foreach (push_q[i]) begin
      push_flit(push_q[i]);
    end
    @(posedge clk);
    push_valid <= 1'b0;

    waited = 0;
    while (pop_idx < pop_q.size()) begin
      waited++;
      if (waited > WAIT_TIMEOUT) begin
        $display("Timeout while waiting for the remaining pop flits");
        abort_run();
      end
      @(posedge clk);
    end

    // The protocol assertions sample the last pop flit on the edge it fires
    @(negedge clk);
    if (uut.u_assert.failures == 0 && pop_q.size() != 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("A protocol assertion failed or the pattern file held no pop flits");
      abort_run();
    end
  end

endmodule

//--- testbench/deser_patterns.txt
// kind (a push, e expected pop) _ last _ don't-care count _ metadata _ data (push data in low byte)
a_0_0_1_00000012
a_0_0_1_00000034
a_0_0_1_00000056
a_0_0_6_00000078
e_0_0_6_12345678
a_0_0_2_0000009a
a_0_0_2_000000bc
a_0_0_2_000000de
a_1_0_2_000000f0
e_1_0_2_9abcdef0
a_1_0_3_000000a5
e_1_3_3_a5000000
a_0_0_7_000000c3
a_1_0_7_0000003c
e_1_2_7_c33c0000
a_0_0_4_00000001
a_0_0_4_00000002
a_1_0_4_00000003
e_1_1_4_01020300
a_1_0_1_0000005a
e_1_3_1_5a000000
a_0_0_5_00000011
a_0_0_5_00000022
a_0_0_5_00000033
a_0_0_5_00000044
e_0_0_5_11223344
a_0_0_2_00000055
a_0_0_2_00000066
a_1_0_0_00000077
e_1_1_0_55667700

//--- tb.f
hdl/deser_pkg.sv
hdl/flit_lane_if.sv
hdl/flit_sequencer.sv
hdl/slice_stager.sv
hdl/pop_assembler.sv
hdl/flow_deserializer.sv
testbench/flow_deserializer_assert.sv
testbench/tb_flow_deserializer.sv

//--- run.sh
#!/bin/sh
set -e
verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f \
  --top-module tb_flow_deserializer -o sim_flow_deserializer
./obj_dir/sim_flow_deserializer +verilator+error+limit+10 2>&1 | tee sim.log
if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
